//--- cnn_params.svh
`ifndef CNN_PARAMS_SVH
`define CNN_PARAMS_SVH

// Float16 word
`define DATA_WIDTH          16

// Feature-map RAM geometry
`define FM_ADDR_WIDTH       8
`define FM_RAM_DEPTH        256
// Base of the upper half
`define FM_RAM_HALF         128

// Configuration limits
// Map sizes up to 8
`define FM_SIZE_WIDTH       4
`define FM_DEPTH_WIDTH      3
// Window sizes 1 to 4
`define POOL_SIZE_WIDTH     3
// Window area up to 16 samples
`define SAMPLE_COUNT_WIDTH  5
`define LAYER_NUM_WIDTH     4

`endif

//--- cnn_pkg.sv
`default_nettype none

`include "cnn_params.svh"

package cnn_pkg;

	// One float16 word
	typedef logic [`DATA_WIDTH-1:0] fp16_t;

	// Feature-map RAM address
	typedef logic [`FM_ADDR_WIDTH-1:0] fm_addr_t;

	// Layer codes as driven by the host
	typedef enum logic [3:0] {
		LAYER_INIT = 4'd0,
		LAYER_CONV = 4'd1,
		LAYER_POOL = 4'd2,
		LAYER_FC   = 4'd3,
		LAYER_DONE = 4'd9
	} layer_type_e;

	// Pool engine FSM states
	typedef enum logic [2:0] {
		IDLE,
		READ,
		DRAIN,
		WRITE,
		NEXT
	} pool_state_e;

	// RAM request, 26 bits
	typedef struct packed {
		logic     valid;
		logic     write;
		fm_addr_t addr;
		fp16_t    data;
	} fm_req_t;

	// Pool layer configuration
	typedef struct packed {
		logic [`FM_SIZE_WIDTH-1:0]   fm_size;
		logic [`FM_DEPTH_WIDTH-1:0]  fm_depth;
		logic [`POOL_SIZE_WIDTH-1:0] pool_win_size;
	} pool_cfg_t;

endpackage

`default_nettype wire

//--- fm_ram.sv
`default_nettype none

`include "cnn_params.svh"

module fm_ram (
	input  wire                       clk,
	input  wire                       en_i,
	input  wire                       we_i,
	input  wire  [`FM_ADDR_WIDTH-1:0] addr_i,
	input  wire  [`DATA_WIDTH-1:0]    wdata_i,
	output logic [`DATA_WIDTH-1:0]    rdata_o
);

	// Both halves of the feature map live here
	logic [`DATA_WIDTH-1:0] mem [`FM_RAM_DEPTH];

	// Single port, one access per cycle
	always_ff @(posedge clk) begin
		if (en_i) begin
			if (we_i) begin
				mem[addr_i] <= wdata_i;
			end else begin
				// Read data shows up on the next cycle
				rdata_o <= mem[addr_i];
			end
		end
	end

	// A write holds the old read data on the port
	// so the requester only samples it on a read-valid

endmodule

`default_nettype wire

//--- fm_arbiter.sv
`default_nettype none

module fm_arbiter import cnn_pkg::*; (
	input  wire          clk,
	input  wire          rst,
	input  wire fm_req_t pool_req_i,
	output logic         pool_gnt_o,
	output logic         pool_rvalid_o,
	input  wire fm_req_t host_req_i,
	output logic         host_gnt_o,
	output logic         host_rvalid_o,
	input  wire fp16_t   rdata_i,
	output fp16_t        rdata_o,
	output fm_req_t      ram_req_o
);

	// Owner of the read issued last cycle
	logic pool_rd_q;
	logic host_rd_q;

	// Fixed priority with the engine ahead of the host
	assign pool_gnt_o = pool_req_i.valid;
	assign host_gnt_o = host_req_i.valid & ~pool_req_i.valid;

	// Mux the granted request onto the RAM port
	always_comb begin
		if (pool_gnt_o) begin
			ram_req_o = pool_req_i;
		end else if (host_gnt_o) begin
			ram_req_o = host_req_i;
		end else begin
			ram_req_o = '0;
		end
	end

	// Track which requester gets the returning word
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pool_rd_q <= 1'b0;
			host_rd_q <= 1'b0;
		end else begin
			pool_rd_q <= pool_gnt_o & ~pool_req_i.write;
			host_rd_q <= host_gnt_o & ~host_req_i.write;
		end
	end

	assign pool_rvalid_o = pool_rd_q;
	assign host_rvalid_o = host_rd_q;
	// Shared return bus, qualified by the read-valids
	assign rdata_o       = rdata_i;

	// Only one owner of the RAM per cycle
	a_one_grant: assert property (@(posedge clk) disable iff (!rst)
		!(pool_gnt_o && host_gnt_o));

	// Any read-valid traces back to a read on the RAM one cycle before
	a_rvalid_after_read: assert property (@(posedge clk) disable iff (!rst)
		(pool_rvalid_o || host_rvalid_o) |-> $past(ram_req_o.valid && !ram_req_o.write));

endmodule

`default_nettype wire

//--- max_pool_unit.sv
`default_nettype none

`include "cnn_params.svh"

module max_pool_unit import cnn_pkg::*; (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           sample_clear_i,
	input  wire  [`SAMPLE_COUNT_WIDTH-1:0] sample_count_i,
	input  wire                           sample_valid_i,
	input  wire fp16_t                    sample_data_i,
	output logic                          result_valid_o,
	output fp16_t                         result_data_o
);

	logic [`SAMPLE_COUNT_WIDTH-1:0] target_q;
	logic [`SAMPLE_COUNT_WIDTH-1:0] count_q;
	fp16_t                          max_q;
	logic                           take_sample;

	// Map sign-magnitude onto an unsigned order
	// Both zeros share one key
	function automatic logic [`DATA_WIDTH-1:0] order_key(input fp16_t v);
		logic [`DATA_WIDTH-1:0] key;
		if (v[`DATA_WIDTH-2:0] == '0) begin
			key = {1'b1, {(`DATA_WIDTH-1){1'b0}}};
		end else if (v[`DATA_WIDTH-1]) begin
			// Larger magnitude sorts lower for negatives
			key = ~v;
		end else begin
			key = {1'b1, v[`DATA_WIDTH-2:0]};
		end
		return key;
	endfunction

	// First sample always loads, later ones only if strictly larger
	assign take_sample = (count_q == '0) || (order_key(sample_data_i) > order_key(max_q));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			target_q       <= '0;
			count_q        <= '0;
			result_valid_o <= 1'b0;
		end else if (sample_clear_i) begin
			target_q       <= sample_count_i;
			count_q        <= '0;
			result_valid_o <= 1'b0;
		end else if (sample_valid_i) begin
			count_q <= count_q + 1'b1;
			// Last counted sample raises the result next cycle
			if (count_q + 1'b1 == target_q) begin
				result_valid_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!sample_clear_i && sample_valid_i && take_sample) begin
			max_q <= sample_data_i;
		end
	end

	assign result_data_o = max_q;

	// Engine must stop feeding once the window is complete
	a_no_late_sample: assert property (@(posedge clk) disable iff (!rst)
		(result_valid_o && !sample_clear_i) |-> !sample_valid_i);

endmodule

`default_nettype wire

//--- pool_engine.sv
`default_nettype none

`include "cnn_params.svh"

module pool_engine import cnn_pkg::*; (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            pool_start_i,
	input  wire                            swap_i,
	input  wire pool_cfg_t                 cfg_i,
	output logic                           pool_done_o,
	output fm_req_t                        ram_req_o,
	input  wire                            ram_gnt_i,
	input  wire                            ram_rvalid_i,
	input  wire fp16_t                     ram_rdata_i,
	output logic                           sample_clear_o,
	output logic [`SAMPLE_COUNT_WIDTH-1:0] sample_count_o,
	output logic                           sample_valid_o,
	output fp16_t                          sample_data_o,
	input  wire                            result_valid_i,
	input  wire fp16_t                     result_data_i
);

	pool_state_e                  state_q;
	pool_cfg_t                    cfg_q;
	logic                         swap_q;
	logic                         done_q;
	logic [`FM_SIZE_WIDTH-1:0]    out_size_q;
	// Window position in the output map
	logic [`FM_DEPTH_WIDTH-1:0]   slice_q;
	logic [`FM_SIZE_WIDTH-1:0]    orow_q;
	logic [`FM_SIZE_WIDTH-1:0]    ocol_q;
	// Sample position inside the window
	logic [`POOL_SIZE_WIDTH-1:0]  wrow_q;
	logic [`POOL_SIZE_WIDTH-1:0]  wcol_q;

	fm_addr_t in_size;
	fm_addr_t out_size;
	fm_addr_t win;
	fm_addr_t in_base;
	fm_addr_t out_base;
	fm_addr_t in_row;
	fm_addr_t in_col;
	fm_addr_t rd_addr;
	fm_addr_t wr_addr;
	logic     win_last_col;
	logic     win_last_row;
	logic     out_last_col;
	logic     out_last_row;
	logic     last_slice;

	// Read from the active half, write to the other one
	assign in_base  = swap_q ? fm_addr_t'(`FM_RAM_HALF) : '0;
	assign out_base = swap_q ? '0 : fm_addr_t'(`FM_RAM_HALF);

	assign in_size  = fm_addr_t'(cfg_q.fm_size);
	assign out_size = fm_addr_t'(out_size_q);
	assign win      = fm_addr_t'(cfg_q.pool_win_size);

	// base + s*size^2 + x*size + y
	assign in_row  = fm_addr_t'(orow_q) * win + fm_addr_t'(wrow_q);
	assign in_col  = fm_addr_t'(ocol_q) * win + fm_addr_t'(wcol_q);
	assign rd_addr = in_base + fm_addr_t'(slice_q) * in_size * in_size
		+ in_row * in_size + in_col;
	assign wr_addr = out_base + fm_addr_t'(slice_q) * out_size * out_size
		+ fm_addr_t'(orow_q) * out_size + fm_addr_t'(ocol_q);

	assign win_last_col = wcol_q == cfg_q.pool_win_size - 1'b1;
	assign win_last_row = wrow_q == cfg_q.pool_win_size - 1'b1;
	assign out_last_col = ocol_q == out_size_q - 1'b1;
	assign out_last_row = orow_q == out_size_q - 1'b1;
	assign last_slice   = slice_q == cfg_q.fm_depth - 1'b1;

	// Max unit hookup
	assign sample_clear_o = state_q == NEXT;
	assign sample_count_o = `SAMPLE_COUNT_WIDTH'(cfg_q.pool_win_size)
		* `SAMPLE_COUNT_WIDTH'(cfg_q.pool_win_size);
	assign sample_valid_o = ram_rvalid_i;
	assign sample_data_o  = ram_rdata_i;
	assign pool_done_o    = done_q;

	// Reads in READ, one result write in WRITE
	always_comb begin
		ram_req_o = '0;
		case (state_q)
			READ: begin
				ram_req_o.valid = 1'b1;
				ram_req_o.addr  = rd_addr;
			end
			WRITE: begin
				ram_req_o.valid = 1'b1;
				ram_req_o.write = 1'b1;
				ram_req_o.addr  = wr_addr;
				ram_req_o.data  = result_data_i;
			end
			default: begin
				ram_req_o = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q    <= IDLE;
			cfg_q      <= '0;
			swap_q     <= 1'b0;
			done_q     <= 1'b0;
			out_size_q <= '0;
			slice_q    <= '0;
			orow_q     <= '0;
			ocol_q     <= '0;
			wrow_q     <= '0;
			wcol_q     <= '0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				IDLE: begin
					if (pool_start_i) begin
						cfg_q      <= cfg_i;
						swap_q     <= swap_i;
						// Edge windows are dropped
						out_size_q <= cfg_i.fm_size / `FM_SIZE_WIDTH'(cfg_i.pool_win_size);
						slice_q    <= '0;
						orow_q     <= '0;
						ocol_q     <= '0;
						wrow_q     <= '0;
						wcol_q     <= '0;
						state_q    <= NEXT;
					end
				end
				// Max unit is cleared here
				NEXT: begin
					state_q <= READ;
				end
				READ: begin
					if (ram_gnt_i) begin
						if (win_last_col) begin
							wcol_q <= '0;
							if (win_last_row) begin
								wrow_q  <= '0;
								state_q <= DRAIN;
							end else begin
								wrow_q <= wrow_q + 1'b1;
							end
						end else begin
							wcol_q <= wcol_q + 1'b1;
						end
					end
				end
				// Last read still in flight
				DRAIN: begin
					if (result_valid_i) begin
						state_q <= WRITE;
					end
				end
				WRITE: begin
					if (ram_gnt_i) begin
						state_q <= NEXT;
						// Column first, then row, then slice
						if (out_last_col) begin
							ocol_q <= '0;
							if (out_last_row) begin
								orow_q <= '0;
								if (last_slice) begin
									slice_q <= '0;
									done_q  <= 1'b1;
									state_q <= IDLE;
								end else begin
									slice_q <= slice_q + 1'b1;
								end
							end else begin
								orow_q <= orow_q + 1'b1;
							end
						end else begin
							ocol_q <= ocol_q + 1'b1;
						end
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// Controller only starts a layer when the engine is free
	a_start_when_idle: assert property (@(posedge clk) disable iff (!rst)
		pool_start_i |-> state_q == IDLE);

endmodule

`default_nettype wire

//--- layer_ctrl.sv
`default_nettype none

`include "cnn_params.svh"

module layer_ctrl import cnn_pkg::*; (
	input  wire                        clk,
	input  wire                        rst,
	input  wire layer_type_e           layer_type_i,
	input  wire [`LAYER_NUM_WIDTH-1:0] layer_num_i,
	input  wire                        init_done_i,
	input  wire                        pool_done_i,
	output logic                       pool_start_o,
	output logic                       swap_o,
	output logic                       init_fm_ram_ready_o,
	output logic                       layer_ready_o
);

	logic [`LAYER_NUM_WIDTH-1:0] cur_layer_q;
	// New pool layer seen, start not yet sent
	logic                        armed_q;
	// Engine is running a layer
	logic                        busy_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cur_layer_q         <= '0;
			armed_q             <= 1'b0;
			busy_q              <= 1'b0;
			pool_start_o        <= 1'b0;
			swap_o              <= 1'b0;
			init_fm_ram_ready_o <= 1'b0;
			layer_ready_o       <= 1'b0;
		end else begin
			pool_start_o <= 1'b0;

			// Start goes out one cycle after ready drops
			if (armed_q && !busy_q) begin
				armed_q      <= 1'b0;
				busy_q       <= 1'b1;
				pool_start_o <= 1'b1;
			end

			// End of layer flips the active half
			if (busy_q && pool_done_i) begin
				busy_q        <= 1'b0;
				swap_o        <= ~swap_o;
				layer_ready_o <= 1'b1;
			end

			case (layer_type_i)
				LAYER_INIT: begin
					if (!layer_ready_o) begin
						if (init_done_i) begin
							init_fm_ram_ready_o <= 1'b1;
						end
						if (init_fm_ram_ready_o) begin
							layer_ready_o <= 1'b1;
						end
					end
				end
				LAYER_POOL: begin
					if (init_fm_ram_ready_o && layer_num_i != cur_layer_q) begin
						cur_layer_q   <= layer_num_i;
						layer_ready_o <= 1'b0;
						armed_q       <= 1'b1;
					end
				end
				// No compute units for these
				LAYER_CONV, LAYER_FC: begin
				end
				// Back to idle, RAM contents stay
				LAYER_DONE: begin
					cur_layer_q   <= '0;
					armed_q       <= 1'b0;
					busy_q        <= 1'b0;
					pool_start_o  <= 1'b0;
					layer_ready_o <= 1'b0;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- cnn_pool_layer.sv
`default_nettype none

`include "cnn_params.svh"

module cnn_pool_layer import cnn_pkg::*; (
	input  wire                        clk,
	input  wire                        rst,
	input  wire layer_type_e           layer_type_i,
	input  wire [`LAYER_NUM_WIDTH-1:0] layer_num_i,
	input  wire                        init_done_i,
	input  wire pool_cfg_t             cfg_i,
	input  wire fm_req_t               host_req_i,
	output logic                       host_gnt_o,
	output logic                       host_rvalid_o,
	output fp16_t                      host_rdata_o,
	output logic                       init_fm_ram_ready_o,
	output logic                       layer_ready_o
);

	// Controller to engine
	logic                           pool_start;
	logic                           swap;
	logic                           pool_done;
	// Engine side of the arbiter
	fm_req_t                        pool_req;
	logic                           pool_gnt;
	logic                           pool_rvalid;
	fp16_t                          rdata;
	// Arbiter to RAM
	fm_req_t                        ram_req;
	fp16_t                          ram_rdata;
	// Engine to max unit
	logic                           sample_clear;
	logic [`SAMPLE_COUNT_WIDTH-1:0] sample_count;
	logic                           sample_valid;
	fp16_t                          sample_data;
	logic                           result_valid;
	fp16_t                          result_data;

	// Host sees the shared return bus
	assign host_rdata_o = rdata;

	layer_ctrl u_layer_ctrl (
		.clk                 (clk),
		.rst                 (rst),
		.layer_type_i        (layer_type_i),
		.layer_num_i         (layer_num_i),
		.init_done_i         (init_done_i),
		.pool_done_i         (pool_done),
		.pool_start_o        (pool_start),
		.swap_o              (swap),
		.init_fm_ram_ready_o (init_fm_ram_ready_o),
		.layer_ready_o       (layer_ready_o)
	);

	pool_engine u_pool_engine (
		.clk            (clk),
		.rst            (rst),
		.pool_start_i   (pool_start),
		.swap_i         (swap),
		.cfg_i          (cfg_i),
		.pool_done_o    (pool_done),
		.ram_req_o      (pool_req),
		.ram_gnt_i      (pool_gnt),
		.ram_rvalid_i   (pool_rvalid),
		.ram_rdata_i    (rdata),
		.sample_clear_o (sample_clear),
		.sample_count_o (sample_count),
		.sample_valid_o (sample_valid),
		.sample_data_o  (sample_data),
		.result_valid_i (result_valid),
		.result_data_i  (result_data)
	);

	max_pool_unit u_max_pool_unit (
		.clk            (clk),
		.rst            (rst),
		.sample_clear_i (sample_clear),
		.sample_count_i (sample_count),
		.sample_valid_i (sample_valid),
		.sample_data_i  (sample_data),
		.result_valid_o (result_valid),
		.result_data_o  (result_data)
	);

	fm_arbiter u_fm_arbiter (
		.clk           (clk),
		.rst           (rst),
		.pool_req_i    (pool_req),
		.pool_gnt_o    (pool_gnt),
		.pool_rvalid_o (pool_rvalid),
		.host_req_i    (host_req_i),
		.host_gnt_o    (host_gnt_o),
		.host_rvalid_o (host_rvalid_o),
		.rdata_i       (ram_rdata),
		.rdata_o       (rdata),
		.ram_req_o     (ram_req)
	);

	fm_ram u_fm_ram (
		.clk     (clk),
		.en_i    (ram_req.valid),
		.we_i    (ram_req.write),
		.addr_i  (ram_req.addr),
		.wdata_i (ram_req.data),
		.rdata_o (ram_rdata)
	);

endmodule

`default_nettype wire

//--- tb_cnn_pool_layer.sv
`default_nettype none

`include "cnn_params.svh"

module tb_cnn_pool_layer import cnn_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int CLK_PERIOD  = 100;
	localparam int RST_CYCLES  = 4;
	// Bound for one grant or flag wait
	localparam int WAIT_CYCLES = 300;
	// Worst command is four host accesses
	localparam int CMD_CYCLES  = 4 * (WAIT_CYCLES + 2);

	logic                        clk;
	logic                        rst;
	layer_type_e                 layer_type;
	logic [`LAYER_NUM_WIDTH-1:0] layer_num;
	logic                        init_done;
	pool_cfg_t                   cfg;
	fm_req_t                     host_req;
	logic                        host_gnt;
	logic                        host_rvalid;
	fp16_t                       host_rdata;
	logic                        init_fm_ram_ready;
	logic                        layer_ready;

	// Parsed commands from the cases file
	string                       op_q[$];
	string                       name_q[$];
	logic [5:0][15:0]            arg_q[$];
	logic                        cmds_loaded;
	int                          mismatch_errors;
	int                          other_errors;

	cnn_pool_layer DUT (
		.clk                 (clk),
		.rst                 (rst),
		.layer_type_i        (layer_type),
		.layer_num_i         (layer_num),
		.init_done_i         (init_done),
		.cfg_i               (cfg),
		.host_req_i          (host_req),
		.host_gnt_o          (host_gnt),
		.host_rvalid_o       (host_rvalid),
		.host_rdata_o        (host_rdata),
		.init_fm_ram_ready_o (init_fm_ram_ready),
		.layer_ready_o       (layer_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Flag 0 is the RAM ready level, flag 1 the layer ready level
	function automatic logic flag_value(input int which);
		return (which == 0) ? init_fm_ram_ready : layer_ready;
	endfunction

	task automatic check_word(input string name, input fp16_t exp, input fp16_t act);
		if (act !== exp) begin
			mismatch_errors++;
			$display("mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			mismatch_errors++;
			$display("mismatch %s expected %b actual %b", name, exp, act);
		end
	endtask

	// Lines are: op, six hex fields, name
	task automatic load_cases();
		int          fd;
		int          n;
		string       line;
		string       op;
		string       name;
		logic [15:0] f [6];
		fd = $fopen("pool_cases.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open pool_cases.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line.substr(0, 0) == "#") begin
					continue;
				end
				n = $sscanf(line, "%s %h %h %h %h %h %h %s", op, f[0], f[1], f[2], f[3],
					f[4], f[5], name);
				if (n != 8) begin
					other_errors++;
					$write("unreadable line in cases file: %s", line);
				end else begin
					op_q.push_back(op);
					name_q.push_back(name);
					arg_q.push_back({f[5], f[4], f[3], f[2], f[1], f[0]});
				end
			end
			$fclose(fd);
		end
		cmds_loaded = 1'b1;
	endtask

	// One host access, held until granted
	task automatic host_access(input logic wr, input fm_addr_t addr, input fp16_t data,
		input string name);
		int   cycles;
		logic granted;
		cycles = 0;
		@(posedge clk);
		host_req <= '{valid: 1'b1, write: wr, addr: addr, data: wr ? data : '0};
		@(negedge clk);
		// Engine traffic keeps the grant low
		while (!host_gnt && cycles < WAIT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		granted = host_gnt;
		if (!granted) begin
			other_errors++;
			$display("%s: host request to address %h was never granted", name, addr);
		end
		// Request is taken on this edge
		@(posedge clk);
		host_req <= '0;
		@(negedge clk);
		if (!wr && granted) begin
			check_flag({name, " rvalid"}, 1'b1, host_rvalid);
			check_word(name, data, host_rdata);
		end
	endtask

	task automatic wait_flag(input int which, input logic val, input string name);
		int cycles;
		cycles = 0;
		while (flag_value(which) !== val && cycles < WAIT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (flag_value(which) !== val) begin
			other_errors++;
			$display("%s: flag %0d did not reach %b within %0d cycles", name, which, val,
				WAIT_CYCLES);
		end
	endtask

	task automatic set_layer(input logic [15:0] kind, input logic [15:0] num);
		@(posedge clk);
		layer_type <= layer_type_e'(kind[3:0]);
		layer_num  <= num[`LAYER_NUM_WIDTH-1:0];
		@(negedge clk);
	endtask

	task automatic set_config(input logic [15:0] size, input logic [15:0] depth,
		input logic [15:0] win);
		@(posedge clk);
		cfg <= '{fm_size: size[`FM_SIZE_WIDTH-1:0], fm_depth: depth[`FM_DEPTH_WIDTH-1:0],
			pool_win_size: win[`POOL_SIZE_WIDTH-1:0]};
		@(negedge clk);
	endtask

	task automatic set_init_done(input logic level);
		@(posedge clk);
		init_done <= level;
		@(negedge clk);
	endtask

	// Every command starts and ends at a falling edge
	task automatic run_command(input int i);
		string            op;
		string            name;
		logic [5:0][15:0] a;
		int               cnt;
		op   = op_q[i];
		name = name_q[i];
		a    = arg_q[i];
		if (op == "W" || op == "R") begin
			cnt = int'(a[1]);
			for (int k = 0; k < cnt && k < 4; k++) begin
				host_access(op == "W", fm_addr_t'(a[0] + 16'(k)), a[2 + k],
					$sformatf("%s[%0d]", name, k));
			end
		end else if (op == "C") begin
			set_config(a[0], a[1], a[2]);
		end else if (op == "T") begin
			set_layer(a[0], a[1]);
		end else if (op == "D") begin
			set_init_done(a[0][0]);
		end else if (op == "Y") begin
			wait_flag(int'(a[0]), a[1][0], name);
		end else if (op == "F") begin
			check_flag(name, a[1][0], flag_value(int'(a[0])));
		end else begin
			other_errors++;
			$display("%s: unknown command %s", name, op);
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	initial begin
		mismatch_errors = 0;
		other_errors    = 0;
		cmds_loaded     = 1'b0;
		rst        <= 1'b0;
		layer_type <= LAYER_INIT;
		layer_num  <= '0;
		init_done  <= 1'b0;
		cfg        <= '0;
		host_req   <= '0;
		load_cases();
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		// Port side comes out of reset idle
		check_flag("host_gnt_after_reset", 1'b0, host_gnt);
		check_flag("host_rvalid_after_reset", 1'b0, host_rvalid);
		for (int i = 0; i < op_q.size(); i++) begin
			run_command(i);
		end
		finish_run();
	end

	// Watchdog scaled to the number of commands
	initial begin
		wait (cmds_loaded);
		repeat (RST_CYCLES + 10 + op_q.size() * CMD_CYCLES) @(posedge clk);
		other_errors++;
		$display("watchdog expired before the last command finished");
		$display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- pool_cases.txt
# op a0 a1 a2 a3 a4 a5 name ; W/R: a0 address, a1 word count, a2..a5 words loaded or expected
# C: size depth window ; T: layer type, number ; D: init_done level
# Y: wait until flag a0 equals a1 ; F: flag a0 equals a1 now ; flag 0 fm ready, 1 layer ready
F 0 0 0 0 0 0 rst_fm_ready_low
F 1 0 0 0 0 0 rst_layer_ready_low
W 00 4 3c00 4000 bc00 3400 load_row0
W 04 4 3800 4200 c800 3000 load_row1
W 08 4 8000 0000 c000 bc00 load_row2
W 0c 4 bc00 c000 c200 c400 load_row3
R 00 4 3c00 4000 bc00 3400 readback_row0
R 0c 4 bc00 c000 c200 c400 readback_row3
D 1 0 0 0 0 0 init_done
Y 0 1 0 0 0 0 fm_ready_rises
F 1 0 0 0 0 0 layer_ready_after_fm_ready
Y 1 1 0 0 0 0 init_layer_ready
C 4 1 2 0 0 0 cfg_4x4_win2
T 2 1 0 0 0 0 pool_layer1
Y 1 0 0 0 0 0 layer1_ready_drops
Y 1 1 0 0 0 0 layer1_done
R 80 4 4200 3400 8000 bc00 layer1_maxima
W 84 4 5640 57d0 5700 57d0 load_slice1
C 2 2 2 0 0 0 cfg_2x2x2_win2
T 2 2 0 0 0 0 pool_layer2
Y 1 0 0 0 0 0 layer2_ready_drops
R 05 1 4200 0 0 0 host_read_during_layer
Y 1 1 0 0 0 0 layer2_done
R 00 2 4200 57d0 0 0 layer2_maxima
R 80 4 4200 3400 8000 bc00 upper_half_kept
T 9 0 0 0 0 0 layer_done
Y 1 0 0 0 0 0 done_drops_ready
F 0 1 0 0 0 0 fm_ready_kept

//--- filelist.f
+incdir+.
cnn_pkg.sv
fm_ram.sv
fm_arbiter.sv
max_pool_unit.sv
pool_engine.sv
layer_ctrl.sv
cnn_pool_layer.sv
tb_cnn_pool_layer.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_cnn_pool_layer
FILELIST   := filelist.f
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST FAILED
PASS_MSG   := TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG) && grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
